//--- bench/clk_gen.sv
// clock and reset source for the testbench; reset is synchronous and held for reset_cycles edges
`timescale 1ns/1ps

module clk_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst
);
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/led_checker.sv
// led_ctrl_top checker; exact static and blink checks only at full brightness, tick_cycles must match
`timescale 1ns/1ps

module led_checker #(
  parameter int tick_cycles = 10
) (
  input  logic           clk,
  input  logic           rst,
  input  led_pkg::byte_t rxd,
  input  logic           rxv,
  input  logic [1:0]     led,
  output int             value_errors,
  output int             blink_errors,
  output int             pwm_errors,
  output int             intervals_checked,
  output int             windows_checked
);
  import led_pkg::*;

  typedef struct packed {
    led_state_t  state;
    logic        in_frame;
    logic [1:0]  cnt;       // data bytes seen
    param_addr_t addr;
    param_t      data;
    param_t      period;
    bright_t     brightness;
    logic        wrote;     // last byte closed a write frame
  } model_t;

  localparam int      led_latency  = 3;
  localparam int      write_settle = 30;  // scan reaches any address within 20 cycles
  localparam bright_t full         = bright_t'(pwm_steps);

  model_t     model;
  model_t     next;
  led_state_t pipe [0:led_latency-1];
  logic [1:0] hist [0:pwm_steps-1];  // led over the last 100 cycles
  logic [1:0] prev_led;
  logic       toggle_valid;
  logic       blink_steady;
  int cycle, cmd_steady, write_steady, steady, last_toggle, interval, high0, high1;

  function automatic bright_t clip(input param_t value);
    return (value > param_t'(pwm_steps)) ? full : value[6:0];
  endfunction

  // reference model of the state after one valid byte
  function automatic model_t next_model(input model_t m, input byte_t b);
    model_t n;
    n = m;
    n.wrote = 1'b0;
    if (m.in_frame) begin
      n.data = {m.data[23:0], b};  // msb first
      n.cnt  = m.cnt + 2'd1;
      if (m.cnt == 2'd3) begin
        n.in_frame = 1'b0;
        n.wrote    = 1'b1;
        if (m.addr == addr_period) n.period = n.data;
        if (m.addr == addr_brightness) n.brightness = clip(n.data);
      end
    end else if ((b & write_flag) != '0) begin
      n.in_frame = 1'b1;
      n.cnt      = 2'd0;
      n.addr     = b[3:0];
    end else begin
      case (b)
        byte_t'(cmd_blink_on): n.state.mode = blink;
        byte_t'(cmd_all_on):   n.state = '{mode: stat, level: 2'b11};
        byte_t'(cmd_all_off):  n.state = '{mode: stat, level: 2'b00};
        byte_t'(cmd_led0_on):  n.state = '{mode: stat, level: {m.state.level[1], 1'b1}};
        byte_t'(cmd_led0_off): n.state = '{mode: stat, level: {m.state.level[1], 1'b0}};
        byte_t'(cmd_led1_on):  n.state = '{mode: stat, level: {1'b1, m.state.level[0]}};
        byte_t'(cmd_led1_off): n.state = '{mode: stat, level: {1'b0, m.state.level[0]}};
        default: ;  // ignored codes
      endcase
    end
    return n;
  endfunction

  //////////////////////////////
  // sampled on the falling edge where led is stable
  always @(negedge clk) begin
    if (rst) begin
      model = '0;
      model.state.mode = blink;
      model.period     = def_period;
      model.brightness = full;
      for (int i = 0; i < led_latency; i++) pipe[i] = model.state;
      for (int i = 0; i < pwm_steps; i++) hist[i] = 2'b00;
      prev_led = 2'b00;
      toggle_valid = 1'b0;
      {cycle, cmd_steady, write_steady, last_toggle} = '0;
      {value_errors, blink_errors, pwm_errors, intervals_checked, windows_checked} = '0;
    end else begin
      if (cycle == 0 && led !== 2'b00) begin
        value_errors++;
        $display("ERROR %0d ns: led %b after reset, expected 00", $time, led);
      end
      // static levels lag the byte by 3 cycles
      if (pipe[led_latency-1].mode == stat && model.brightness == full
          && cycle >= write_steady && led !== pipe[led_latency-1].level) begin
        value_errors++;
        $display("ERROR %0d ns: led %b, expected %b", $time, led, pipe[led_latency-1].level);
      end
      for (int i = pwm_steps - 1; i > 0; i--) hist[i] = hist[i-1];
      hist[0] = led;
      steady = (cmd_steady > write_steady) ? cmd_steady : write_steady;
      if (model.state.mode == stat && cycle - (pwm_steps - 1) >= steady) begin
        high0 = 0;
        high1 = 0;
        for (int i = 0; i < pwm_steps; i++) begin
          high0 += int'(hist[i][0]);
          high1 += int'(hist[i][1]);
        end
        windows_checked++;
        if (high0 != (model.state.level[0] ? int'(model.brightness) : 0)
            || high1 != (model.state.level[1] ? int'(model.brightness) : 0)) begin
          pwm_errors++;
          $display("ERROR %0d ns: window high counts %0d/%0d, brightness %0d, level %b",
                   $time, high0, high1, model.brightness, model.state.level);
        end
      end
      // blink toggles
      interval = (int'(model.period) + 1) * tick_cycles;
      blink_steady = pipe[led_latency-1].mode == blink && model.brightness == full
                     && cycle >= steady;
      if (blink_steady && led[0] !== led[1]) begin
        blink_errors++;
        $display("ERROR %0d ns: blinking bits differ, led %b", $time, led);
      end
      if (led !== prev_led) begin
        if (blink_steady && toggle_valid && last_toggle >= steady) begin
          intervals_checked++;
          if (cycle - last_toggle != interval) begin
            blink_errors++;
            $display("ERROR %0d ns: blink interval %0d cycles, expected %0d",
                     $time, cycle - last_toggle, interval);
          end
        end
        last_toggle  = cycle;
        toggle_valid = 1'b1;
      end else if (blink_steady && toggle_valid && last_toggle >= steady
                   && cycle - last_toggle > interval) begin
        blink_errors++;
        $display("ERROR %0d ns: no blink toggle within %0d cycles", $time, interval);
        last_toggle = cycle;
      end
      prev_led = led;
      // byte seen now is taken by the DUT on the next rising edge
      if (rxv === 1'b1) begin
        next = next_model(model, rxd);
        if (next.state != model.state) cmd_steady = cycle + led_latency;
        if (next.wrote) write_steady = cycle + write_settle;
        model = next;
      end
      for (int i = led_latency - 1; i > 0; i--) pipe[i] = pipe[i-1];
      pipe[0] = model.state;
      cycle++;
    end
  end

endmodule

//--- bench/led_tb.sv
// testbench top for led_ctrl_top; tick_cycles 10, random byte gaps from a fixed seed
`timescale 1ns/1ps

module led_tb;
  import led_pkg::*;

  localparam int tick_cycles   = 10;
  localparam int max_gap       = 4;
  localparam int byte_max      = max_gap + 1;
  localparam int frame_max     = 5 * byte_max;  // header and four data bytes
  localparam int blink_wait    = 130;
  localparam int static_wait   = 8;
  localparam int pwm_wait      = 240;
  localparam int period_wait   = 170;
  localparam int min_intervals = 4;
  localparam int max_cycles    = 5 + blink_wait + 10 * (byte_max + static_wait)
                               + 2 * (byte_max + frame_max + period_wait) + 2 * byte_max
                               + 5 * (frame_max + pwm_wait) + 200;

  logic       clk;
  logic       rst;
  byte_t      rxd;
  logic       rxv;
  logic [1:0] led;
  int seed;
  int run_cycles = 0;
  int value_errors, blink_errors, pwm_errors, intervals_checked, windows_checked;

  clk_gen i_clk_gen (.clk(clk), .rst(rst));

  led_ctrl_top #(.tick_cycles(tick_cycles)) i_led_ctrl_top (
    .clk (clk),
    .rst (rst),
    .rxd (rxd),
    .rxv (rxv),
    .led (led)
  );

  led_checker #(.tick_cycles(tick_cycles)) i_led_checker (
    .clk               (clk),
    .rst               (rst),
    .rxd               (rxd),
    .rxv               (rxv),
    .led               (led),
    .value_errors      (value_errors),
    .blink_errors      (blink_errors),
    .pwm_errors        (pwm_errors),
    .intervals_checked (intervals_checked),
    .windows_checked   (windows_checked)
  );

  // one byte and up to gap_max idle cycles of junk on rxd
  task automatic drive_byte(input byte_t value, input int gap_max);
    logic [31:0] rnd;
    int gap;
    @(posedge clk);
    rxd <= value;
    rxv <= 1'b1;
    rnd = $random(seed);
    gap = int'(rnd[2:0]) % (gap_max + 1);
    repeat (gap) begin
      @(posedge clk);
      rxv <= 1'b0;
      rxd <= rnd[15:8];
    end
  endtask

  task automatic send_write(input param_addr_t addr, input param_t data, input int gap_max);
    drive_byte(write_flag | {4'h0, addr}, gap_max);
    for (int i = 3; i >= 0; i--) drive_byte(data[8*i +: 8], gap_max);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      rxv <= 1'b0;
    end
  endtask

  task automatic send_static(input byte_t value);
    drive_byte(value, max_gap);
    wait_cycles(static_wait);
  endtask

  initial begin
    seed = 95510;
    rxd  = '0;
    rxv  = 1'b0;
    while (rst !== 1'b0) @(posedge clk);
    wait_cycles(blink_wait);  // default blink with period 4
    send_static(byte_t'(cmd_all_on));
    send_static(byte_t'(cmd_led0_off));
    send_static(8'h00);
    send_static(byte_t'(cmd_led1_off));
    send_static(byte_t'(cmd_led0_on));
    send_static(8'h0b);
    send_static(byte_t'(cmd_led1_on));
    send_static(8'h7f);
    send_static(byte_t'(cmd_led0_off));
    send_static(byte_t'(cmd_all_off));
    drive_byte(byte_t'(cmd_blink_on), max_gap);
    send_write(addr_period, 32'd2, 0);
    wait_cycles(period_wait);
    // PWM windows in stat with all on
    drive_byte(byte_t'(cmd_all_on), max_gap);
    send_write(addr_brightness, 32'd37, 0);
    wait_cycles(pwm_wait);
    send_write(addr_brightness, 32'd0, 0);
    wait_cycles(pwm_wait);
    send_write(addr_brightness, 32'd120, 0);  // clipped to 100
    wait_cycles(pwm_wait);
    // same writes broken up by gaps
    send_write(addr_brightness, 32'd37, max_gap);
    wait_cycles(pwm_wait);
    send_write(addr_brightness, 32'd100, max_gap);
    wait_cycles(pwm_wait);
    drive_byte(byte_t'(cmd_all_off), max_gap);
    drive_byte(byte_t'(cmd_blink_on), max_gap);
    send_write(addr_period, 32'd3, max_gap);
    wait_cycles(period_wait);

    $display("errors: value %0d, blink %0d, pwm %0d; intervals checked %0d, windows checked %0d",
             value_errors, blink_errors, pwm_errors, intervals_checked, windows_checked);
    if (intervals_checked < min_intervals || windows_checked == 0) begin
      $display("too few blink intervals or PWM windows were checked");
    end
    if (value_errors + blink_errors + pwm_errors == 0 && intervals_checked >= min_intervals
        && windows_checked > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= max_cycles) begin
      $display("timeout: the command sequence did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

//--- build.sh
#!/bin/sh
# compile and run the led_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --top-module led_tb \
  -f led_ctrl.f --Mdir "$build_dir" -o led_sim
if [ $? -ne 0 ]; then
  echo "build.sh: compile failed"
  exit 1
fi

"./$build_dir/led_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "build.sh: simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
  exit 1
fi
exit 0

//--- led_ctrl.f
src/led_pkg.sv
src/cmd_decoder.sv
src/param_ram.sv
src/led_mode.sv
src/blink_scan.sv
src/led_output.sv
src/led_ctrl_top.sv
bench/clk_gen.sv
bench/led_checker.sv
bench/led_tb.sv

//--- src/blink_scan.sv
// RAM scanner and blink timer; tick_cycles must be at least 2, period counts ms ticks
`timescale 1ns/1ps

module blink_scan #(
  parameter int unsigned tick_cycles = 125000  // clocks per ms tick
) (
  input  logic                 clk,
  input  logic                 rst,
  output led_pkg::param_addr_t rd_addr,
  input  led_pkg::param_t      rd_data,
  output led_pkg::led_drive_t  drive
);
  import led_pkg::*;

  param_addr_t rd_addr_dl;  // address that matches rd_data
  param_t      period;
  bright_t     brightness;

  logic [$clog2(tick_cycles)-1:0] tick_cnt;
  logic                           tick;
  param_t                         blink_cnt;

  //////////////////////////////
  // settings scan
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr    <= scan_start;
      rd_addr_dl <= scan_start;
      period     <= def_period;
      brightness <= bright_t'(def_brightness);
    end else begin
      rd_addr    <= (rd_addr == scan_stop) ? scan_start : rd_addr + 4'd1;
      rd_addr_dl <= rd_addr;
      case (rd_addr_dl)
        addr_period: period <= rd_data;
        addr_brightness: begin
          if (rd_data > param_t'(pwm_steps)) begin
            brightness <= bright_t'(pwm_steps);  // clip to full on
          end else begin
            brightness <= rd_data[6:0];
          end
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // ms tick and blink toggle
  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt     <= '0;
      tick         <= 1'b0;
      blink_cnt    <= '0;
      drive.toggle <= 1'b0;
    end else begin
      if (tick_cnt == $bits(tick_cnt)'(tick_cycles - 1)) begin
        tick_cnt <= '0;
        tick     <= 1'b1;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
        tick     <= 1'b0;
      end
      if (tick) begin
        blink_cnt <= (blink_cnt >= period) ? '0 : blink_cnt + 32'd1;  // >= covers a shrunk period
      end
      drive.toggle <= tick && (blink_cnt == '0);
    end
  end

  assign drive.brightness = brightness;

endmodule

//--- src/cmd_decoder.sv
// byte stream parser; no framing recovery, a write header always consumes the next four valid bytes
`timescale 1ns/1ps

module cmd_decoder (
  input  logic               clk,
  input  logic               rst,
  input  led_pkg::byte_t     rxd,
  input  logic               rxv,
  output led_pkg::led_cmd_t  cmd,
  output led_pkg::param_wr_t wr
);
  import led_pkg::*;

  typedef enum logic {idle, data} dec_state_t;

  dec_state_t  state;
  logic [1:0]  byte_cnt;  // data bytes seen in this frame
  param_addr_t addr_q;
  param_t      shift;     // msb first
  logic        wr_en;

  logic is_write;
  logic is_exec;

  assign is_write = (rxd & write_flag) != '0;
  assign is_exec  = (rxd >= byte_t'(cmd_blink_on)) && (rxd <= byte_t'(cmd_led1_off));

  //////////////////////////////
  // frame state machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      byte_cnt <= '0;
      cmd.val  <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      cmd.val <= 1'b0;  // strobes last one cycle
      wr_en   <= 1'b0;
      if (rxv) begin
        case (state)
          idle: begin
            if (is_write) begin
              addr_q   <= rxd[3:0];
              byte_cnt <= '0;
              state    <= data;
            end else if (is_exec) begin
              cmd.val  <= 1'b1;
              cmd.code <= rxd[2:0];
            end
            // codes 0 and 8..127 fall through
          end
          data: begin
            shift    <= {shift[23:0], rxd};
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin  // fourth data byte
              wr_en <= 1'b1;
              state <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // write port comes straight from the frame registers
  always_comb begin
    wr.en   = wr_en;
    wr.addr = addr_q;
    wr.data = shift;
  end

endmodule

//--- src/led_ctrl_top.sv
// LED controller top; rxd/rxv are plain TCP receive data, there is no back-pressure
`timescale 1ns/1ps

module led_ctrl_top #(
  parameter int unsigned tick_cycles = 125000
) (
  input  logic           clk,
  input  logic           rst,
  input  led_pkg::byte_t rxd,
  input  logic           rxv,
  output logic [1:0]     led
);
  import led_pkg::*;

  led_cmd_t    cmd;
  param_wr_t   wr;
  param_addr_t rd_addr;
  param_t      rd_data;
  led_state_t  state;
  led_drive_t  drive;

  cmd_decoder i_cmd_decoder (
    .clk (clk),
    .rst (rst),
    .rxd (rxd),
    .rxv (rxv),
    .cmd (cmd),
    .wr  (wr)
  );

  param_ram i_param_ram (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  led_mode i_led_mode (
    .clk   (clk),
    .rst   (rst),
    .cmd   (cmd),
    .state (state)
  );

  blink_scan #(.tick_cycles(tick_cycles)) i_blink_scan (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .drive   (drive)
  );

  led_output i_led_output (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .drive (drive),
    .led   (led)
  );

endmodule

//--- src/led_mode.sv
// mode tracker; only valid strobes change state, unknown codes leave it as is
`timescale 1ns/1ps

module led_mode (
  input  logic                clk,
  input  logic                rst,
  input  led_pkg::led_cmd_t   cmd,
  output led_pkg::led_state_t state
);
  import led_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      state.mode  <= blink;  // board comes up blinking
      state.level <= 2'b00;
    end else if (cmd.val) begin
      case (cmd.code)
        cmd_blink_on: begin
          state.mode <= blink;  // levels kept for the next stat command
        end
        cmd_all_on: begin
          state.mode  <= stat;
          state.level <= 2'b11;
        end
        cmd_all_off: begin
          state.mode  <= stat;
          state.level <= 2'b00;
        end
        cmd_led0_on: begin
          state.mode     <= stat;
          state.level[0] <= 1'b1;
        end
        cmd_led0_off: begin
          state.mode     <= stat;
          state.level[0] <= 1'b0;
        end
        cmd_led1_on: begin
          state.mode     <= stat;
          state.level[1] <= 1'b1;
        end
        cmd_led1_off: begin
          state.mode     <= stat;
          state.level[1] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- src/led_output.sv
// output stage; brightness above pwm_steps is never seen here, the scanner clips it
`timescale 1ns/1ps

module led_output (
  input  logic                clk,
  input  logic                rst,
  input  led_pkg::led_state_t state,
  input  led_pkg::led_drive_t drive,
  output logic [1:0]          led
);
  import led_pkg::*;

  bright_t    pwm_cnt;  // 0 .. pwm_steps-1
  logic       pwm_on;
  logic [1:0] drive_q;
  logic [1:0] drive_next;

  // next drive value, levels in stat, toggles in blink
  always_comb begin
    drive_next = drive_q;
    if (state.mode == stat) begin
      drive_next = state.level;
    end else if (drive.toggle) begin
      drive_next = ~drive_q;
    end
  end

  assign pwm_on = pwm_cnt < drive.brightness;

  //////////////////////////////
  // drive register and PWM gate
  always_ff @(posedge clk) begin
    if (rst) begin
      pwm_cnt <= '0;
      drive_q <= 2'b00;
      led     <= 2'b00;
    end else begin
      pwm_cnt <= (pwm_cnt == bright_t'(pwm_steps - 1)) ? '0 : pwm_cnt + 7'd1;
      drive_q <= drive_next;
      led     <= drive_next & {2{pwm_on}};  // same cycle as drive_q, keeps latency at 3
    end
  end

endmodule

//--- src/led_pkg.sv
// shared LED controller definitions; command codes 1..7 only, RAM fixed at 16 words of 32 bits
package led_pkg;

  typedef logic [7:0]  byte_t;        // one stream byte
  typedef logic [3:0]  param_addr_t;  // settings RAM address
  typedef logic [31:0] param_t;       // settings word
  typedef logic [2:0]  cmd_code_t;    // execute command code
  typedef logic [6:0]  bright_t;      // brightness in PWM steps

  typedef enum logic {stat, blink} led_mode_t;

  typedef struct packed {
    logic      val;
    cmd_code_t code;
  } led_cmd_t;

  typedef struct packed {
    logic        en;
    param_addr_t addr;
    param_t      data;
  } param_wr_t;

  typedef struct packed {
    led_mode_t  mode;
    logic [1:0] level;  // bit 0 is led0
  } led_state_t;

  typedef struct packed {
    logic    toggle;
    bright_t brightness;
  } led_drive_t;

  //////////////////////////////
  // command codes
  localparam cmd_code_t cmd_blink_on = 3'd1;
  localparam cmd_code_t cmd_all_on   = 3'd2;
  localparam cmd_code_t cmd_all_off  = 3'd3;
  localparam cmd_code_t cmd_led0_on  = 3'd4;
  localparam cmd_code_t cmd_led0_off = 3'd5;
  localparam cmd_code_t cmd_led1_on  = 3'd6;
  localparam cmd_code_t cmd_led1_off = 3'd7;

  localparam byte_t write_flag = 8'h80;  // first byte of a write frame

  //////////////////////////////
  // settings RAM map and defaults
  localparam param_addr_t addr_brightness = 4'd1;
  localparam param_addr_t addr_period     = 4'd2;
  localparam param_addr_t scan_start      = 4'd0;
  localparam param_addr_t scan_stop       = 4'd15;

  localparam param_t def_brightness = 32'd100;
  localparam param_t def_period     = 32'd4;   // in ms ticks, interval is period+1

  localparam int pwm_steps = 100;

endpackage

//--- src/param_ram.sv
// settings store; reset takes several cycles of rst to settle the read port on defaults
`timescale 1ns/1ps

module param_ram (
  input  logic                 clk,
  input  logic                 rst,
  input  led_pkg::param_wr_t   wr,
  input  led_pkg::param_addr_t rd_addr,
  output led_pkg::param_t      rd_data
);
  import led_pkg::*;

  param_t mem [0:(1 << $bits(param_addr_t)) - 1];

  // write port, defaults on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < $size(mem); i++) begin
        mem[i] <= '0;
      end
      mem[addr_brightness] <= def_brightness;
      mem[addr_period]     <= def_period;
    end else if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule
